//--- csr_top.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/trap_pkg.sv
hdl/trap_if.sv
hdl/trap_arbiter.sv
hdl/csr_counters.sv
hdl/csr_file.sv
hdl/csr_top.sv
dv/csr_top_tb.sv

//--- dv/csr_top_tb.sv
`timescale 1ns/1ps

`include "core_params.svh"

module csr_top_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 6;

    logic                   clk_i;
    logic                   rstn_i;
    logic                   dec_valid_i;
    logic [`PC_W-1:0]       dec_pc_i;
    logic [`CAUSE_W-1:0]    dec_cause_i;
    logic                   exe_valid_i;
    logic [`PC_W-1:0]       exe_pc_i;
    logic [`CAUSE_W-1:0]    exe_cause_i;
    logic [`XLEN-1:0]       exe_info_i;
    logic                   mem_valid_i;
    logic [`PC_W-1:0]       mem_pc_i;
    logic [`CAUSE_W-1:0]    mem_cause_i;
    logic [`CSR_ADDR_W-1:0] rd_addr_i;
    logic                   rd_valid_i;
    logic [`CSR_ADDR_W-1:0] wr_addr_i;
    logic [`XLEN-1:0]       wr_data_i;
    logic                   wr_valid_i;
    logic                   retire_i;
    logic [`XLEN-1:0]       csr_rdata_o;
    logic                   csr_rvalid_o;
    logic                   flush_o;
    logic [`PC_W-1:0]       redirect_pc_o;
    logic                   redirect_valid_o;

    logic [31:0] lfsr_state = 32'hb1f6;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    csr_top uut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Galois LFSR, taps 32, 22, 2 and 1; the shifted-out bit is the random bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        wr_addr_i  = addr;
        wr_data_i  = data;
        wr_valid_i = 1'b1;
        @(negedge clk_i);
        wr_valid_i = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
        rd_addr_i  = addr;
        rd_valid_i = 1'b1;
        #5; // Combinational read settles well before the next rising edge.
        check_value("csr_rvalid_o", csr_rvalid_o, 1);
        data = csr_rdata_o;
        @(negedge clk_i);
        rd_valid_i = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [11:0] addr,
                              input logic [31:0] exp);
        logic [31:0] d;
        csr_read(addr, d);
        check_value(name, d, exp);
    endtask

    // Holds the reports set up by the caller for one cycle and checks the redirect.
    task automatic pulse_reports(input logic [31:0] exp_pc);
        #5;
        check_value("flush_o", flush_o, 1);
        check_value("redirect_valid_o", redirect_valid_o, 1);
        check_value("redirect_pc_o", redirect_pc_o, exp_pc);
        @(negedge clk_i);
        dec_valid_i = 1'b0;
        exe_valid_i = 1'b0;
        mem_valid_i = 1'b0;
    endtask

    function automatic logic [31:0] mstatus_value(input logic mie, input logic mpie);
        logic [31:0] v;
        v = '0;
        v[csr_pkg::MSTATUS_MPP +: 2] = 2'b11;
        v[csr_pkg::MSTATUS_MIE]      = mie;
        v[csr_pkg::MSTATUS_MPIE]     = mpie;
        return v;
    endfunction

    task automatic test_reset();
        int e0 = errors;
        check_value("flush_o", flush_o, 0);
        check_value("redirect_valid_o", redirect_valid_o, 0);
        check_value("csr_rvalid_o", csr_rvalid_o, 0);
        read_check("misa", csr_pkg::ADDR_MISA, csr_pkg::MISA_RESET);
        read_check("mstatus", csr_pkg::ADDR_MSTATUS, mstatus_value(0, 0));
        read_check("mvendorid", csr_pkg::ADDR_MVENDORID, 0);
        read_check("marchid", csr_pkg::ADDR_MARCHID, 0);
        read_check("mimpid", csr_pkg::ADDR_MIMPID, 0);
        read_check("mhartid", csr_pkg::ADDR_MHARTID, 0);
        read_check("mtvec", csr_pkg::ADDR_MTVEC, 0);
        read_check("mepc", csr_pkg::ADDR_MEPC, 0);
        check_value("flush_o", flush_o, 0);
        report_test("reset", e0);
    endtask

    task automatic test_read_write();
        int          e0 = errors;
        logic [11:0] ro_addr [5] = '{csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID,
                                     csr_pkg::ADDR_MIMPID, csr_pkg::ADDR_MHARTID, 12'h7C0};
        logic [31:0] v;
        v = take_bits(32);
        csr_write(csr_pkg::ADDR_MTVEC, v);
        read_check("mtvec", csr_pkg::ADDR_MTVEC, v);
        v = take_bits(32);
        csr_write(csr_pkg::ADDR_MEPC, v);
        read_check("mepc", csr_pkg::ADDR_MEPC, v);
        v = take_bits(32);
        csr_write(csr_pkg::ADDR_MTVAL, v);
        read_check("mtval", csr_pkg::ADDR_MTVAL, v);
        csr_write(csr_pkg::ADDR_MISA, take_bits(32));
        read_check("misa", csr_pkg::ADDR_MISA, csr_pkg::MISA_RESET);
        foreach (ro_addr[i]) begin
            csr_write(ro_addr[i], take_bits(32));
            read_check($sformatf("csr_rdata_o at 0x%0h", ro_addr[i]), ro_addr[i], 0);
        end
        report_test("read_write", e0);
    endtask

    task automatic test_trap_entry();
        int          e0 = errors;
        logic [31:0] vec;
        logic [31:0] pc;
        logic [31:0] info;
        vec  = take_bits(32);
        pc   = take_bits(32);
        info = take_bits(32);
        csr_write(csr_pkg::ADDR_MTVEC, vec);
        csr_write(csr_pkg::ADDR_MSTATUS, mstatus_value(1, 0));
        exe_valid_i = 1'b1;
        exe_pc_i    = pc;
        exe_cause_i = trap_pkg::CAUSE_ILLEGAL;
        exe_info_i  = info;
        pulse_reports({vec[31:2], 2'b00});
        read_check("mepc", csr_pkg::ADDR_MEPC, pc);
        read_check("mcause", csr_pkg::ADDR_MCAUSE, 32'(trap_pkg::CAUSE_ILLEGAL));
        read_check("mtval", csr_pkg::ADDR_MTVAL, info);
        read_check("mstatus", csr_pkg::ADDR_MSTATUS, mstatus_value(0, 1));
        report_test("trap_entry", e0);
    endtask

    task automatic test_priority();
        int          e0 = errors;
        logic [31:0] vec;
        vec = take_bits(32);
        csr_write(csr_pkg::ADDR_MTVEC, vec);
        dec_valid_i = 1'b1;
        dec_pc_i    = take_bits(32);
        dec_cause_i = trap_pkg::CAUSE_ILLEGAL;
        exe_valid_i = 1'b1;
        exe_pc_i    = take_bits(32);
        exe_cause_i = trap_pkg::CAUSE_ECALL_M;
        exe_info_i  = take_bits(32) | 32'h1;
        mem_valid_i = 1'b1;
        mem_pc_i    = take_bits(32);
        mem_cause_i = trap_pkg::CAUSE_LOAD_MISALIGN;
        pulse_reports({vec[31:2], 2'b00});
        read_check("mepc", csr_pkg::ADDR_MEPC, mem_pc_i);
        read_check("mcause", csr_pkg::ADDR_MCAUSE, 32'(trap_pkg::CAUSE_LOAD_MISALIGN));
        read_check("mtval", csr_pkg::ADDR_MTVAL, 0); // Memory reports carry no info.
        dec_valid_i = 1'b1;
        exe_valid_i = 1'b1;
        pulse_reports({vec[31:2], 2'b00});
        read_check("mepc", csr_pkg::ADDR_MEPC, exe_pc_i);
        read_check("mcause", csr_pkg::ADDR_MCAUSE, 32'(trap_pkg::CAUSE_ECALL_M));
        read_check("mtval", csr_pkg::ADDR_MTVAL, exe_info_i);
        report_test("priority", e0);
    endtask

    task automatic test_mret();
        int          e0 = errors;
        logic [31:0] vec;
        logic [31:0] pc;
        vec = take_bits(32);
        pc  = take_bits(32);
        csr_write(csr_pkg::ADDR_MTVEC, vec);
        csr_write(csr_pkg::ADDR_MSTATUS, mstatus_value(1, 0));
        dec_valid_i = 1'b1;
        dec_pc_i    = pc;
        dec_cause_i = trap_pkg::CAUSE_ILLEGAL;
        pulse_reports({vec[31:2], 2'b00});
        exe_valid_i = 1'b1;
        exe_pc_i    = take_bits(32);
        exe_cause_i = trap_pkg::CAUSE_MRET;
        exe_info_i  = take_bits(32);
        pulse_reports(pc);
        read_check("mstatus", csr_pkg::ADDR_MSTATUS, mstatus_value(1, 1));
        read_check("mepc", csr_pkg::ADDR_MEPC, pc);
        read_check("mcause", csr_pkg::ADDR_MCAUSE, 32'(trap_pkg::CAUSE_ILLEGAL));
        read_check("mtval", csr_pkg::ADDR_MTVAL, 0);
        report_test("mret", e0);
    endtask

    task automatic test_counters();
        int          e0 = errors;
        int          n;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] base;
        csr_read(csr_pkg::ADDR_MCYCLE, a);
        csr_read(csr_pkg::ADDR_MCYCLE, b);
        check_value("mcycle delta", b - a, 1);
        n = int'(take_bits(4)) + 1;
        csr_read(csr_pkg::ADDR_MINSTRET, a);
        retire_i = 1'b1;
        repeat (n) @(negedge clk_i);
        retire_i = 1'b0;
        csr_read(csr_pkg::ADDR_MINSTRET, b);
        check_value("minstret delta", b - a, n);
        base = {take_bits(32), take_bits(32) & 32'h0FFF_FFFF}; // No carry out of the low half.
        csr_write(csr_pkg::ADDR_MCYCLE, base[31:0]);
        csr_write(csr_pkg::ADDR_MCYCLEH, base[63:32]);
        read_check("mcycle", csr_pkg::ADDR_MCYCLE, base[31:0] + 32'd1);
        read_check("mcycleh", csr_pkg::ADDR_MCYCLEH, base[63:32]);
        report_test("counters", e0);
    endtask

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk_i);
        $display("Watchdog timeout, the tests did not finish in time.");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk_i = 1'b0;
        rstn_i = 1'b0;
        dec_valid_i = 1'b0;
        dec_pc_i = '0;
        dec_cause_i = '0;
        exe_valid_i = 1'b0;
        exe_pc_i = '0;
        exe_cause_i = '0;
        exe_info_i = '0;
        mem_valid_i = 1'b0;
        mem_pc_i = '0;
        mem_cause_i = '0;
        rd_addr_i = '0;
        rd_valid_i = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        wr_valid_i = 1'b0;
        retire_i = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        test_reset();
        test_read_write();
        test_trap_entry();
        test_priority();
        test_mret();
        test_counters();
        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- hdl/csr_top.sv
`timescale 1ns/1ps

`include "core_params.svh"

module csr_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  logic                    dec_valid_i,
    input  logic [`PC_W-1:0]        dec_pc_i,
    input  logic [`CAUSE_W-1:0]     dec_cause_i,

    input  logic                    exe_valid_i,
    input  logic [`PC_W-1:0]        exe_pc_i,
    input  logic [`CAUSE_W-1:0]     exe_cause_i,
    input  logic [`XLEN-1:0]        exe_info_i,

    input  logic                    mem_valid_i,
    input  logic [`PC_W-1:0]        mem_pc_i,
    input  logic [`CAUSE_W-1:0]     mem_cause_i,

    input  logic [`CSR_ADDR_W-1:0]  rd_addr_i,
    input  logic                    rd_valid_i,
    input  logic [`CSR_ADDR_W-1:0]  wr_addr_i,
    input  logic [`XLEN-1:0]        wr_data_i,
    input  logic                    wr_valid_i,

    input  logic                    retire_i,

    output logic [`XLEN-1:0]        csr_rdata_o,
    output logic                    csr_rvalid_o,
    output logic                    flush_o,
    output logic [`PC_W-1:0]        redirect_pc_o,
    output logic                    redirect_valid_o
);

    trap_if dec_if ();
    trap_if exe_if ();
    trap_if mem_if ();

    trap_pkg::trap_rec_t trap_rec;

    logic                mcycle_load_lo;
    logic                mcycle_load_hi;
    logic                minstret_load_lo;
    logic                minstret_load_hi;
    logic [`XLEN-1:0]    ctr_wdata;
    logic [`CTR_W-1:0]   mcycle;
    logic [`CTR_W-1:0]   minstret;

    assign dec_if.valid = dec_valid_i;
    assign dec_if.pc    = dec_pc_i;
    assign dec_if.cause = dec_cause_i;
    assign dec_if.info  = '0; // Decode reports carry no trap value.

    assign exe_if.valid = exe_valid_i;
    assign exe_if.pc    = exe_pc_i;
    assign exe_if.cause = exe_cause_i;
    assign exe_if.info  = exe_info_i;

    assign mem_if.valid = mem_valid_i;
    assign mem_if.pc    = mem_pc_i;
    assign mem_if.cause = mem_cause_i;
    assign mem_if.info  = '0;

    trap_arbiter u_trap_arbiter (
        .mem_i  (mem_if.sink),
        .exe_i  (exe_if.sink),
        .dec_i  (dec_if.sink),
        .trap_o (trap_rec)
    );

    csr_file u_csr_file (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .trap_i             (trap_rec),
        .rd_addr_i          (rd_addr_i),
        .rd_valid_i         (rd_valid_i),
        .wr_addr_i          (wr_addr_i),
        .wr_data_i          (wr_data_i),
        .wr_valid_i         (wr_valid_i),
        .mcycle_i           (mcycle),
        .minstret_i         (minstret),
        .mcycle_load_lo_o   (mcycle_load_lo),
        .mcycle_load_hi_o   (mcycle_load_hi),
        .minstret_load_lo_o (minstret_load_lo),
        .minstret_load_hi_o (minstret_load_hi),
        .wdata_o            (ctr_wdata),
        .csr_rdata_o        (csr_rdata_o),
        .csr_rvalid_o       (csr_rvalid_o),
        .flush_o            (flush_o),
        .redirect_pc_o      (redirect_pc_o),
        .redirect_valid_o   (redirect_valid_o)
    );

    csr_counters u_csr_counters (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .retire_i           (retire_i),
        .wdata_i            (ctr_wdata),
        .mcycle_load_lo_i   (mcycle_load_lo),
        .mcycle_load_hi_i   (mcycle_load_hi),
        .minstret_load_lo_i (minstret_load_lo),
        .minstret_load_hi_i (minstret_load_hi),
        .mcycle_o           (mcycle),
        .minstret_o         (minstret)
    );

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps

`include "core_params.svh"

module csr_file (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  trap_pkg::trap_rec_t      trap_i,
    input  logic [`CSR_ADDR_W-1:0]   rd_addr_i,
    input  logic                     rd_valid_i,
    input  logic [`CSR_ADDR_W-1:0]   wr_addr_i,
    input  logic [`XLEN-1:0]         wr_data_i,
    input  logic                     wr_valid_i,
    input  logic [`CTR_W-1:0]        mcycle_i,
    input  logic [`CTR_W-1:0]        minstret_i,
    output logic                     mcycle_load_lo_o,
    output logic                     mcycle_load_hi_o,
    output logic                     minstret_load_lo_o,
    output logic                     minstret_load_hi_o,
    output logic [`XLEN-1:0]         wdata_o,
    output logic [`XLEN-1:0]         csr_rdata_o,
    output logic                     csr_rvalid_o,
    output logic                     flush_o,
    output logic [`PC_W-1:0]         redirect_pc_o,
    output logic                     redirect_valid_o
);

    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] mstatush_q;
    logic [`XLEN-1:0] mie_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic [`XLEN-1:0] mtval_q;
    logic [`XLEN-1:0] mtinst_q;

    logic [`XLEN-1:0] mstatus_trap;
    logic [`XLEN-1:0] mstatus_mret;
    logic             is_mret;

    csr_pkg::csr_idx_t rd_idx;
    csr_pkg::csr_idx_t wr_idx;

    function automatic csr_pkg::csr_idx_t addr_to_idx(input logic [`CSR_ADDR_W-1:0] addr);
        case (addr)
            csr_pkg::ADDR_MVENDORID: addr_to_idx = csr_pkg::MVENDORID;
            csr_pkg::ADDR_MARCHID:   addr_to_idx = csr_pkg::MARCHID;
            csr_pkg::ADDR_MIMPID:    addr_to_idx = csr_pkg::MIMPID;
            csr_pkg::ADDR_MHARTID:   addr_to_idx = csr_pkg::MHARTID;
            csr_pkg::ADDR_MSTATUS:   addr_to_idx = csr_pkg::MSTATUS;
            csr_pkg::ADDR_MISA:      addr_to_idx = csr_pkg::MISA;
            csr_pkg::ADDR_MIE:       addr_to_idx = csr_pkg::MIE;
            csr_pkg::ADDR_MTVEC:     addr_to_idx = csr_pkg::MTVEC;
            csr_pkg::ADDR_MSTATUSH:  addr_to_idx = csr_pkg::MSTATUSH;
            csr_pkg::ADDR_MEPC:      addr_to_idx = csr_pkg::MEPC;
            csr_pkg::ADDR_MCAUSE:    addr_to_idx = csr_pkg::MCAUSE;
            csr_pkg::ADDR_MTVAL:     addr_to_idx = csr_pkg::MTVAL;
            csr_pkg::ADDR_MTINST:    addr_to_idx = csr_pkg::MTINST;
            csr_pkg::ADDR_MCYCLE:    addr_to_idx = csr_pkg::MCYCLE;
            csr_pkg::ADDR_MCYCLEH:   addr_to_idx = csr_pkg::MCYCLEH;
            csr_pkg::ADDR_MINSTRET:  addr_to_idx = csr_pkg::MINSTRET;
            csr_pkg::ADDR_MINSTRETH: addr_to_idx = csr_pkg::MINSTRETH;
            default:                 addr_to_idx = csr_pkg::UNIMPL;
        endcase
    endfunction

    assign rd_idx  = addr_to_idx(rd_addr_i);
    assign wr_idx  = addr_to_idx(wr_addr_i);
    assign is_mret = trap_i.cause == trap_pkg::CAUSE_MRET;

    always_comb begin
        mstatus_trap = mstatus_q;
        mstatus_trap[csr_pkg::MSTATUS_MPIE]  = mstatus_q[csr_pkg::MSTATUS_MIE];
        mstatus_trap[csr_pkg::MSTATUS_MIE]   = 1'b0;
        mstatus_trap[csr_pkg::MSTATUS_MPP +: 2] = csr_pkg::PRIV_M;

        mstatus_mret = mstatus_q;
        mstatus_mret[csr_pkg::MSTATUS_MIE]  = mstatus_q[csr_pkg::MSTATUS_MPIE];
        mstatus_mret[csr_pkg::MSTATUS_MPIE] = 1'b1;
    end

    always_comb begin
        case (rd_idx)
            csr_pkg::MSTATUS:   csr_rdata_o = mstatus_q;
            csr_pkg::MISA:      csr_rdata_o = csr_pkg::MISA_RESET;
            csr_pkg::MIE:       csr_rdata_o = mie_q;
            csr_pkg::MTVEC:     csr_rdata_o = mtvec_q;
            csr_pkg::MSTATUSH:  csr_rdata_o = mstatush_q;
            csr_pkg::MEPC:      csr_rdata_o = mepc_q;
            csr_pkg::MCAUSE:    csr_rdata_o = mcause_q;
            csr_pkg::MTVAL:     csr_rdata_o = mtval_q;
            csr_pkg::MTINST:    csr_rdata_o = mtinst_q;
            csr_pkg::MCYCLE:    csr_rdata_o = mcycle_i[`XLEN-1:0];
            csr_pkg::MCYCLEH:   csr_rdata_o = mcycle_i[`CTR_W-1:`XLEN];
            csr_pkg::MINSTRET:  csr_rdata_o = minstret_i[`XLEN-1:0];
            csr_pkg::MINSTRETH: csr_rdata_o = minstret_i[`CTR_W-1:`XLEN];
            default:            csr_rdata_o = '0; // ID registers and unknown addresses.
        endcase
    end

    assign csr_rvalid_o = rd_valid_i;

    // Counters live in csr_counters, a write here only raises its load strobe.
    assign mcycle_load_lo_o   = wr_valid_i && (wr_idx == csr_pkg::MCYCLE);
    assign mcycle_load_hi_o   = wr_valid_i && (wr_idx == csr_pkg::MCYCLEH);
    assign minstret_load_lo_o = wr_valid_i && (wr_idx == csr_pkg::MINSTRET);
    assign minstret_load_hi_o = wr_valid_i && (wr_idx == csr_pkg::MINSTRETH);
    assign wdata_o            = wr_data_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mstatus_q  <= '0;
            mstatus_q[csr_pkg::MSTATUS_MPP +: 2] <= csr_pkg::PRIV_M;
            mstatush_q <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            mtinst_q   <= '0;
        end else begin
            if (wr_valid_i) begin
                case (wr_idx)
                    csr_pkg::MSTATUS:  mstatus_q  <= wr_data_i;
                    csr_pkg::MIE:      mie_q      <= wr_data_i;
                    csr_pkg::MTVEC:    mtvec_q    <= wr_data_i;
                    csr_pkg::MSTATUSH: mstatush_q <= wr_data_i;
                    csr_pkg::MEPC:     mepc_q     <= wr_data_i;
                    csr_pkg::MCAUSE:   mcause_q   <= wr_data_i;
                    csr_pkg::MTVAL:    mtval_q    <= wr_data_i;
                    csr_pkg::MTINST:   mtinst_q   <= wr_data_i;
                    default: ;
                endcase
            end
            // Placed after the write so a trap overrides it on the same register.
            if (trap_i.valid) begin
                if (is_mret) begin
                    mstatus_q <= mstatus_mret;
                end else begin
                    mstatus_q <= mstatus_trap;
                    mepc_q    <= trap_i.pc;
                    mcause_q  <= {{(`XLEN-`CAUSE_W){1'b0}}, trap_i.cause};
                    mtval_q   <= trap_i.info;
                end
            end
        end
    end

    assign flush_o          = trap_i.valid;
    assign redirect_valid_o = trap_i.valid;
    assign redirect_pc_o    = is_mret ? mepc_q : {mtvec_q[`PC_W-1:2], 2'b00}; // Direct mode only.

endmodule

//--- hdl/csr_counters.sv
`timescale 1ns/1ps

`include "core_params.svh"

module csr_counters (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               retire_i,
    input  logic [`XLEN-1:0]   wdata_i,
    input  logic               mcycle_load_lo_i,
    input  logic               mcycle_load_hi_i,
    input  logic               minstret_load_lo_i,
    input  logic               minstret_load_hi_i,
    output logic [`CTR_W-1:0]  mcycle_o,
    output logic [`CTR_W-1:0]  minstret_o
);

    logic [`CTR_W-1:0] mcycle_q;
    logic [`CTR_W-1:0] minstret_q;

    // A loaded half takes the write data, the other half keeps the counted value.
    function automatic logic [`CTR_W-1:0] next_count(
        input logic [`CTR_W-1:0] cur,
        input logic              inc,
        input logic              load_lo,
        input logic              load_hi,
        input logic [`XLEN-1:0]  wdata
    );
        logic [`CTR_W-1:0] nxt;
        nxt = cur + {{(`CTR_W-1){1'b0}}, inc};
        if (load_lo) begin
            nxt[`XLEN-1:0] = wdata;
        end
        if (load_hi) begin
            nxt[`CTR_W-1:`XLEN] = wdata;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q   <= next_count(mcycle_q, 1'b1, mcycle_load_lo_i, mcycle_load_hi_i, wdata_i);
            minstret_q <= next_count(minstret_q, retire_i, minstret_load_lo_i,
                                     minstret_load_hi_i, wdata_i);
        end
    end

    assign mcycle_o   = mcycle_q;
    assign minstret_o = minstret_q;

endmodule

//--- hdl/trap_arbiter.sv
`timescale 1ns/1ps

module trap_arbiter (
    trap_if.sink                 mem_i,
    trap_if.sink                 exe_i,
    trap_if.sink                 dec_i,
    output trap_pkg::trap_rec_t  trap_o
);

    always_comb begin
        trap_o.valid = mem_i.valid | exe_i.valid | dec_i.valid;

        // The oldest instruction in the pipeline owns the trap.
        if (mem_i.valid) begin
            trap_o.pc    = mem_i.pc;
            trap_o.cause = mem_i.cause;
            trap_o.info  = mem_i.info;
        end else if (exe_i.valid) begin
            trap_o.pc    = exe_i.pc;
            trap_o.cause = exe_i.cause;
            trap_o.info  = exe_i.info;
        end else begin
            trap_o.pc    = dec_i.pc;
            trap_o.cause = dec_i.cause;
            trap_o.info  = dec_i.info;
        end
    end

endmodule

//--- hdl/trap_if.sv
`timescale 1ns/1ps

`include "core_params.svh"

interface trap_if;

    logic              valid;
    logic [`PC_W-1:0]  pc;
    trap_pkg::cause_t  cause;
    logic [`XLEN-1:0]  info; // Faulting address or instruction, stage dependent.

    modport source (
        output valid,
        output pc,
        output cause,
        output info
    );

    modport sink (
        input valid,
        input pc,
        input cause,
        input info
    );

endinterface

//--- hdl/trap_pkg.sv
`include "core_params.svh"

package trap_pkg;

    typedef logic [`CAUSE_W-1:0] cause_t;

    localparam cause_t CAUSE_ILLEGAL       = 5'd2;
    localparam cause_t CAUSE_LOAD_MISALIGN = 5'd4;
    localparam cause_t CAUSE_ECALL_M       = 5'd11;

    // Not an architectural code, marks a return from the trap handler.
    localparam cause_t CAUSE_MRET = 5'd31;

    // One exception report after stage arbitration.
    typedef struct packed {
        logic             valid;
        logic [`PC_W-1:0] pc;
        cause_t           cause;
        logic [`XLEN-1:0] info;
    } trap_rec_t;

endpackage

//--- hdl/csr_pkg.sv
`include "core_params.svh"

package csr_pkg;

    // Architectural slots that the CSR file decodes an address into.
    typedef enum logic [`CSR_IDX_W-1:0] {
        MVENDORID,
        MARCHID,
        MIMPID,
        MHARTID,
        MSTATUS,
        MISA,
        MIE,
        MTVEC,
        MSTATUSH,
        MEPC,
        MCAUSE,
        MTVAL,
        MTINST,
        MCYCLE,
        MCYCLEH,
        MINSTRET,
        MINSTRETH,
        UNIMPL
    } csr_idx_t;

    localparam logic [`CSR_ADDR_W-1:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hF14;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MISA      = 12'h301;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MIE       = 12'h304;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MTVEC     = 12'h305;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MSTATUSH  = 12'h310;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MEPC      = 12'h341;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MTVAL     = 12'h343;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MTINST    = 12'h34A;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MCYCLE    = 12'hB00;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MINSTRET  = 12'hB02;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MCYCLEH   = 12'hB80;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MINSTRETH = 12'hB82;

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11; // Low bit of the two-bit MPP field.

    localparam logic [1:0] PRIV_M = 2'b11;

    // MXL is 1 for RV32, with the C, I and M extension bits set.
    localparam logic [`XLEN-1:0] MISA_RESET = 32'h4000_1104;

endpackage

//--- hdl/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Register width of the RV32 core.
`define XLEN 32

// Program counter width.
`define PC_W 32

// Width of an mcause exception code.
`define CAUSE_W 5

// Width of a CSR address as given in the privileged spec.
`define CSR_ADDR_W 12

// Width of the internal CSR slot index.
`define CSR_IDX_W 5

// Width of the mcycle and minstret counters.
`define CTR_W 64

`endif
